// ==== build.f ====
verilog/pce_glue_pkg.sv
verilog/cart_loader.sv
verilog/pad_port.sv
verilog/pce_glue_top.sv
verification/pce_glue_assert.sv
verification/pce_glue_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

OBJ_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert \
  --top-module pce_glue_tb \
  -Mdir "$OBJ_DIR" \
  -f build.f

# keep running past assertion errors so the testbench can report them
"./$OBJ_DIR/Vpce_glue_tb" +verilator+error+limit+1000 | tee "$LOG_FILE"

if grep -q "Simulation finished: PASS" "$LOG_FILE"; then
  echo "run_sim: passed"
else
  echo "run_sim: failed"
  exit 1
fi

// ==== verification/pce_glue_tb.sv ====
`timescale 1ns/1ps

module pce_glue_tb
  import pce_glue_pkg::*;
();

  localparam int LOAD_ROWS = 8;
  localparam int PAD_CASES = 4;
  // cycles a pad step is held before joy_in is sampled
  localparam int PAD_SETTLE = 2;
  localparam int WR_WAIT_LIMIT = 4;
  // byte address just past the upper signature row
  localparam int POP_END = (int'(POP_BASE_HI) + 1) * 16;
  // 8 cycles per download word and 40 per pad case plus margin
  localparam int TIMEOUT_CYCLES = 8 * (LOAD_ROWS + POP_END / 2) + 40 * PAD_CASES + 300;

  typedef struct packed {
    logic [ROM_DATA_W-1:0] word;
    logic rev;
    logic [ROM_DATA_W-1:0] exp_data;
  } load_row_t;

  logic clk_sys_42_95;
  logic arst_n;
  logic ioctl_wr;
  logic [ROM_DATA_W-1:0] ioctl_dout;
  logic cart_download;
  host_opts_t opts;
  pad_t [NUM_PADS-1:0] pads;
  logic [1:0] joy_out;
  logic [NIB_W-1:0] joy_in;
  logic rom_wr;
  rom_write_t rom_write;
  logic [1:0] populous;

  // stimulus tables
  load_row_t load_tab [LOAD_ROWS];
  pad_t [NUM_PADS-1:0] case_pads [PAD_CASES];
  // {six_button, multitap}
  logic [1:0] case_opts [PAD_CASES];
  string case_name [PAD_CASES];
  // one char per step for the joy_out code and the expected nibble
  string case_seq [PAD_CASES];
  string case_exp [PAD_CASES];

  integer seed;
  int error_count = 0;
  int check_count = 0;
  int test_count = 0;
  int failed_tests = 0;
  int test_err_start = 0;
  int cycle_count = 0;
  int toggle_count = 0;
  logic rom_wr_seen = 1'b0;
  string cur_test;

  pce_glue_top dut (
    .clk_sys_42_95 (clk_sys_42_95),
    .arst_n        (arst_n),
    .ioctl_wr      (ioctl_wr),
    .ioctl_dout    (ioctl_dout),
    .cart_download (cart_download),
    .opts          (opts),
    .pads          (pads),
    .joy_out       (joy_out),
    .joy_in        (joy_in),
    .rom_wr        (rom_wr),
    .rom_write     (rom_write),
    .populous      (populous)
  );

  initial begin
    clk_sys_42_95 = 1'b0;
    forever #4 clk_sys_42_95 = ~clk_sys_42_95;
  end

  // run limit
  always @(posedge clk_sys_42_95) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, stuck in test %s", cycle_count, cur_test);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // count write toggles on the falling clock edge
  always @(negedge clk_sys_42_95) begin
    if (rom_wr != rom_wr_seen) begin
      toggle_count++;
    end
    rom_wr_seen = rom_wr;
  end

  task automatic load_tables();
    // word, bit_reverse, expected data
    load_tab[0] = '{16'h1234, 1'b0, 16'h1234};
    load_tab[1] = '{16'h1234, 1'b1, 16'h482C};
    load_tab[2] = '{16'h80F1, 1'b1, 16'h018F};
    load_tab[3] = '{16'hA5C3, 1'b0, 16'hA5C3};
    load_tab[4] = '{16'h0F01, 1'b1, 16'hF080};
    load_tab[5] = '{16'hFFFF, 1'b1, 16'hFFFF};
    load_tab[6] = '{16'h6E00, 1'b1, 16'h7600};
    load_tab[7] = '{16'h0102, 1'b0, 16'h0102};
    // pads listed from port 4 down to port 0
    case_name[0] = "pad_standard_a";
    case_pads[0] = {12'h444, 12'h333, 12'h222, 12'h111, 12'h5A9};
    case_opts[0] = 2'b00;
    case_seq[0] = "21010";
    case_exp[0] = "0C5C5";
    case_name[1] = "pad_standard_b";
    case_pads[1] = {12'hFFF, 12'hFFF, 12'hFFF, 12'hFFF, 12'hC36};
    case_opts[1] = 2'b00;
    case_seq[1] = "31020";
    case_exp[1] = "03C0C";
    // sel edges walk ports 1 to 4 and then one empty port
    case_name[2] = "pad_multitap";
    case_pads[2] = {12'h45C, 12'h3F8, 12'h2A4, 12'h111, 12'h000};
    case_opts[2] = 2'b01;
    case_seq[2] = "21010101010";
    case_exp[2] = "0DEB5E0AAFF";
    // phase flips on each clr pulse
    // extended phase reads the id nibble and then ext buttons
    case_name[3] = "pad_six_button";
    case_pads[3] = {12'h000, 12'h000, 12'h000, 12'h000, 12'hA37};
    case_opts[3] = 2'b10;
    case_seq[3] = "210210210";
    case_exp[3] = "00501C005";
  endtask

  // hex character to value
  function automatic logic [3:0] digit_value(input byte c);
    if (c >= 8'h41) begin
      return 4'(c - 8'h37);
    end
    return 4'(c - 8'h30);
  endfunction

  task automatic check_equal(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    if (expected !== actual) begin
      error_count++;
      $display("FAIL %s %s: expected %0h, actual %0h", cur_test, name, expected, actual);
    end
  endtask

  task automatic begin_test(input string name);
    cur_test = name;
    test_err_start = error_count;
  endtask

  task automatic end_test();
    test_count++;
    if (error_count != test_err_start) begin
      failed_tests++;
      $display("test %s: %0d errors", cur_test, error_count - test_err_start);
    end else begin
      $display("test %s: ok", cur_test);
    end
  endtask

  // rising edge of cart_download rearms the address and flags
  task automatic start_download();
    @(posedge clk_sys_42_95);
    cart_download <= 1'b0;
    ioctl_wr <= 1'b0;
    @(posedge clk_sys_42_95);
    cart_download <= 1'b1;
    @(posedge clk_sys_42_95);
    @(negedge clk_sys_42_95);
    check_equal("start addr", 32'h0, 32'(rom_write.addr));
    check_equal("start populous", 32'h3, 32'(populous));
  endtask

  // one host word with the strobe high until the toggle and then low
  task automatic write_word(input logic [ROM_DATA_W-1:0] word, input logic rev,
                            input logic [ROM_DATA_W-1:0] exp_data, input int exp_addr,
                            input string name);
    logic old_wr;
    int waited;
    old_wr = rom_wr;
    waited = 0;
    @(posedge clk_sys_42_95);
    ioctl_dout <= word;
    opts.bit_reverse <= rev;
    ioctl_wr <= 1'b1;
    while (rom_wr == old_wr && waited < WR_WAIT_LIMIT) begin
      @(negedge clk_sys_42_95);
      waited++;
    end
    if (rom_wr == old_wr) begin
      error_count++;
      $display("%s %s: rom_wr never toggled after the write strobe", cur_test, name);
    end
    check_equal({name, " data"}, 32'(exp_data), 32'(rom_write.data));
    check_equal({name, " addr"}, 32'(exp_addr), 32'(rom_write.addr));
    @(posedge clk_sys_42_95);
    ioctl_wr <= 1'b0;
    // address steps on the falling strobe edge
    @(posedge clk_sys_42_95);
  endtask

  task automatic pad_step(input logic [1:0] joy, input logic [3:0] exp_nib, input string name);
    @(posedge clk_sys_42_95);
    joy_out <= joy;
    repeat (PAD_SETTLE) @(posedge clk_sys_42_95);
    @(negedge clk_sys_42_95);
    check_equal(name, 32'(exp_nib), 32'(joy_in));
  endtask

  task automatic run_pad_case(input int c);
    @(posedge clk_sys_42_95);
    pads <= case_pads[c];
    opts.six_button <= case_opts[c][1];
    opts.multitap <= case_opts[c][0];
    joy_out <= 2'b00;
    for (int k = 0; k < case_seq[c].len(); k++) begin
      pad_step(2'(digit_value(case_seq[c][k])), digit_value(case_exp[c][k]),
               $sformatf("step %0d", k));
    end
  endtask

  initial begin
    int toggles_before;
    int row;
    int ofs;
    int assert_fails;
    logic [ROM_DATA_W-1:0] word;
    seed = 32'h91c753af;
    arst_n = 1'b0;
    ioctl_wr = 1'b0;
    ioctl_dout = '0;
    cart_download = 1'b0;
    opts = '0;
    pads = '0;
    joy_out = 2'b00;
    cur_test = "reset";
    load_tables();
    repeat (10) @(posedge clk_sys_42_95);
    arst_n <= 1'b1;
    @(posedge clk_sys_42_95);

    // address steps, toggles and bit reversal
    begin_test("address_and_reversal");
    start_download();
    toggles_before = toggle_count;
    for (int i = 0; i < LOAD_ROWS; i++) begin
      write_word(load_tab[i].word, load_tab[i].rev, load_tab[i].exp_data, 2 * i,
                 $sformatf("word %0d", i));
    end
    check_equal("toggle count", 32'(LOAD_ROWS), 32'(toggle_count - toggles_before));
    end_test();

    // full image up to the upper signature row
    begin_test("populous_detect");
    start_download();
    for (int a = 0; a < POP_END; a += 2) begin
      row = a >> 4;
      ofs = a & 15;
      word = 16'($random(seed));
      if ((row == int'(POP_BASE_LO) || row == int'(POP_BASE_HI)) && ofs >= 6 && ofs <= 12) begin
        word = POP_SIG[2'((ofs - 6) / 2)];
        // corrupt offset 8 of the upper row
        if (row == int'(POP_BASE_HI) && ofs == 8) begin
          word = ~word;
        end
      end
      write_word(word, 1'b0, word, a, $sformatf("addr %0h", a));
    end
    @(negedge clk_sys_42_95);
    check_equal("flags", 32'h1, 32'(populous));
    end_test();

    // flags come back on the next download
    begin_test("populous_restore");
    start_download();
    end_test();

    for (int c = 0; c < PAD_CASES; c++) begin
      begin_test(case_name[c]);
      run_pad_case(c);
      end_test();
    end

    @(posedge clk_sys_42_95);
    assert_fails = int'(dut.u_assert.fail_count);
    $display("tests %0d, failed %0d, checks %0d, mismatches %0d, assertion failures %0d",
             test_count, failed_tests, check_count, error_count, assert_fails);
    if (error_count == 0 && assert_fails == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== verification/pce_glue_assert.sv ====
`timescale 1ns/1ps

module pce_glue_assert
  import pce_glue_pkg::*;
(
  input logic             clk_sys_42_95,
  input logic             arst_n,
  input logic             ioctl_wr,
  input logic             rom_wr,
  input rom_write_t       rom_write,
  input logic [1:0]       joy_out,
  input logic [NIB_W-1:0] joy_in
);

  // read back by the testbench at the end
  int unsigned fail_count = 0;

  // toggle only one cycle after the first high strobe cycle
  wr_toggle_timing: assert property (@(posedge clk_sys_42_95) disable iff (!arst_n)
    (rom_wr != $past(rom_wr)) |-> ($past(ioctl_wr) && !$past(ioctl_wr, 2)))
  else begin
    fail_count++;
    $error("rom_wr toggled outside the first strobe cycle");
  end

  // clr blanks the read nibble on the next cycle
  clr_blanks_joy: assert property (@(posedge clk_sys_42_95) disable iff (!arst_n)
    joy_out[1] |=> (joy_in == '0))
  else begin
    fail_count++;
    $error("joy_in not zero after clr");
  end

  // word addresses stay even
  addr_even: assert property (@(posedge clk_sys_42_95) disable iff (!arst_n)
    rom_write.addr[0] == 1'b0)
  else begin
    fail_count++;
    $error("odd rom write address");
  end

endmodule

bind pce_glue_top pce_glue_assert u_assert (.*);

// ==== verilog/pce_glue_top.sv ====
`timescale 1ns/1ps

module pce_glue_top
  import pce_glue_pkg::*;
(
  input  logic                  clk_sys_42_95,
  input  logic                  arst_n,
  // host download channel
  input  logic                  ioctl_wr,
  input  logic [ROM_DATA_W-1:0] ioctl_dout,
  input  logic                  cart_download,
  // option levels
  input  host_opts_t            opts,
  // pads and console lines
  input  pad_t [NUM_PADS-1:0]   pads,
  input  logic [1:0]            joy_out,
  output logic [NIB_W-1:0]      joy_in,
  // rom write side
  output logic                  rom_wr,
  output rom_write_t            rom_write,
  output logic [1:0]            populous
);

  // rom image loader
  cart_loader u_cart_loader (
    .clk_sys_42_95 (clk_sys_42_95),
    .arst_n        (arst_n),
    .cart_download (cart_download),
    .ioctl_wr      (ioctl_wr),
    .ioctl_dout    (ioctl_dout),
    .bit_reverse   (opts.bit_reverse),
    .rom_write     (rom_write),
    .rom_wr        (rom_wr),
    .populous      (populous)
  );

  // controller port mux
  pad_port u_pad_port (
    .clk_sys_42_95 (clk_sys_42_95),
    .arst_n        (arst_n),
    .pads          (pads),
    .joy_out       (joy_out),
    .six_button    (opts.six_button),
    .multitap      (opts.multitap),
    .joy_in        (joy_in)
  );

endmodule

// ==== verilog/pad_port.sv ====
`timescale 1ns/1ps

module pad_port
  import pce_glue_pkg::*;
(
  input  logic                  clk_sys_42_95,
  input  logic                  arst_n,
  input  pad_t [NUM_PADS-1:0]   pads,
  input  logic [1:0]            joy_out,
  input  logic                  six_button,
  input  logic                  multitap,
  output logic [NIB_W-1:0]      joy_in
);

  // console lines
  logic sel;
  logic clr;

  // last sample of sel and clr
  logic [1:0] joy_out_q;
  logic sel_rise;
  logic clr_rise;

  // multitap port and six-button phase
  logic [PORT_W-1:0] port;
  logic high_buttons;

  // selected pad and its active-low word
  logic port_valid;
  pad_t cur_pad;
  logic [JOY_WORD_W-1:0] joy_data;

  // nibble picked for this read
  pad_nibble_e nib_sel;
  logic [NIB_W-1:0] nibble;

  assign sel = joy_out[0];
  assign clr = joy_out[1];

  assign sel_rise = sel & ~joy_out_q[0];
  assign clr_rise = clr & ~joy_out_q[1];

  // pick the pad on the current port
  // ports past the last pad read as nothing pressed
  always_comb begin
    port_valid = (port < PORT_W'(NUM_PADS));
    cur_pad = '0;
    if (port_valid) begin
      cur_pad = pads[port];
    end
  end

  // console expects low-active buttons
  // top nibble stays 0 for the six-button id
  always_comb begin
    if (port_valid) begin
      joy_data = {
        {NIB_W{1'b0}},
        ~cur_pad.ext_buttons,
        ~{cur_pad.left, cur_pad.down, cur_pad.right, cur_pad.up},
        ~{cur_pad.start, cur_pad.select, cur_pad.button_b, cur_pad.button_a}
      };
    end else begin
      joy_data = JOY_WORD_W'(16'h0FFF);
    end
  end

  // phase picks the high pair of nibbles
  assign nib_sel = pad_nibble_e'({high_buttons, sel});

  always_comb begin
    nibble = joy_data[NIB_W-1:0];
    case (nib_sel)
      NIB_BUTTONS: nibble = joy_data[0*NIB_W +: NIB_W];
      NIB_DPAD:    nibble = joy_data[1*NIB_W +: NIB_W];
      NIB_EXT:     nibble = joy_data[2*NIB_W +: NIB_W];
      NIB_ID:      nibble = joy_data[3*NIB_W +: NIB_W];
      default:     nibble = joy_data[0*NIB_W +: NIB_W];
    endcase
  end

  // edge history
  always_ff @(posedge clk_sys_42_95 or negedge arst_n) begin
    if (!arst_n) begin
      joy_out_q <= 2'b00;
    end else begin
      joy_out_q <= joy_out;
    end
  end

  // port index
  // clr rewinds to the first pad
  // sel edges step through the tap when enabled
  always_ff @(posedge clk_sys_42_95 or negedge arst_n) begin
    if (!arst_n) begin
      port <= '0;
    end else if (clr) begin
      port <= '0;
    end else if (sel_rise && multitap) begin
      port <= port + PORT_W'(1);
    end
  end

  // six-button phase
  // alternates on every clr pulse and stays 0 without six_button
  always_ff @(posedge clk_sys_42_95 or negedge arst_n) begin
    if (!arst_n) begin
      high_buttons <= 1'b0;
    end else if (clr_rise) begin
      high_buttons <= ~high_buttons & six_button;
    end
  end

  // read latch
  // clr blanks the returned nibble
  always_ff @(posedge clk_sys_42_95 or negedge arst_n) begin
    if (!arst_n) begin
      joy_in <= '0;
    end else if (clr) begin
      joy_in <= '0;
    end else begin
      joy_in <= nibble;
    end
  end

endmodule

// ==== verilog/cart_loader.sv ====
`timescale 1ns/1ps

module cart_loader
  import pce_glue_pkg::*;
(
  input  logic                  clk_sys_42_95,
  input  logic                  arst_n,
  input  logic                  cart_download,
  input  logic                  ioctl_wr,
  input  logic [ROM_DATA_W-1:0] ioctl_dout,
  input  logic                  bit_reverse,
  output rom_write_t            rom_write,
  output logic                  rom_wr,
  output logic [1:0]            populous
);

  // previous samples for edge detection
  logic download_q;
  logic wr_q;

  // byte address of the word being written
  logic [ROM_ADDR_W-1:0] addr;

  // word after optional per-byte reversal
  logic [ROM_DATA_W-1:0] data_rev;
  logic [ROM_DATA_W-1:0] wr_data;

  // edge strobes
  logic dl_start;
  logic wr_rise;
  logic wr_fall;

  // populous check
  logic pop_row;
  logic sig_mismatch;

  assign dl_start = cart_download & ~download_q;
  assign wr_rise = ioctl_wr & ~wr_q;
  assign wr_fall = ~ioctl_wr & wr_q;

  // mirror bit order inside every byte
  // byte lanes stay where they are
  always_comb begin
    for (int b = 0; b < ROM_ADDR_STEP; b++) begin
      for (int i = 0; i < 8; i++) begin
        data_rev[8*b+i] = ioctl_dout[8*b+7-i];
      end
    end
  end

  // data follows the host word directly
  assign wr_data = bit_reverse ? data_rev : ioctl_dout;

  assign rom_write.addr = addr;
  assign rom_write.data = wr_data;

  // only two rows of the image matter
  assign pop_row = (addr[ROM_ADDR_W-1:POP_ROW_LSB] == POP_BASE_LO) ||
                   (addr[ROM_ADDR_W-1:POP_ROW_LSB] == POP_BASE_HI);

  // compare against the signature word for this offset
  // offsets outside the signature never mismatch
  always_comb begin
    sig_mismatch = 1'b0;
    for (int i = 0; i < POP_SIG_WORDS; i++) begin
      if ((addr[POP_ROW_LSB-1:0] == POP_SIG_OFS[i]) && (wr_data != POP_SIG[i])) begin
        sig_mismatch = 1'b1;
      end
    end
  end

  // host strobe and download level history
  always_ff @(posedge clk_sys_42_95 or negedge arst_n) begin
    if (!arst_n) begin
      download_q <= 1'b0;
      wr_q <= 1'b0;
    end else begin
      download_q <= cart_download;
      wr_q <= ioctl_wr;
    end
  end

  // address counter
  // cleared at download start and stepped after each word
  always_ff @(posedge clk_sys_42_95 or negedge arst_n) begin
    if (!arst_n) begin
      addr <= '0;
    end else if (dl_start) begin
      addr <= '0;
    end else if (wr_fall) begin
      addr <= addr + ROM_ADDR_W'(ROM_ADDR_STEP);
    end
  end

  // write request toggles once per word
  // each change means new addr and data
  always_ff @(posedge clk_sys_42_95 or negedge arst_n) begin
    if (!arst_n) begin
      rom_wr <= 1'b0;
    end else if (!dl_start && wr_rise) begin
      rom_wr <= ~rom_wr;
    end
  end

  // both flags armed per download
  // a wrong word clears the flag of its row
  always_ff @(posedge clk_sys_42_95 or negedge arst_n) begin
    if (!arst_n) begin
      populous <= 2'b11;
    end else if (dl_start) begin
      populous <= 2'b11;
    end else if (wr_rise && pop_row && sig_mismatch) begin
      // bit 13 is low for the lower row
      populous[addr[POP_SEL_BIT]] <= 1'b0;
    end
  end

endmodule

// ==== verilog/pce_glue_pkg.sv ====
package pce_glue_pkg;

  // rom download path
  localparam int ROM_ADDR_W = 24;
  localparam int ROM_DATA_W = 16;

  // bytes per download word, also the address step
  localparam int ROM_ADDR_STEP = ROM_DATA_W / 8;

  // low address bits give the offset inside a 16-byte row
  localparam int POP_ROW_LSB = 4;
  localparam int POP_ROW_W = ROM_ADDR_W - POP_ROW_LSB;

  // address bit that picks the populous flag
  localparam int POP_SEL_BIT = 13;

  // rows that carry the populous signature
  localparam logic [POP_ROW_W-1:0] POP_BASE_LO = 20'h001F2;
  localparam logic [POP_ROW_W-1:0] POP_BASE_HI = 20'h00212;

  // signature words and their row offsets
  localparam int POP_SIG_WORDS = 4;
  localparam logic [POP_SIG_WORDS-1:0][ROM_DATA_W-1:0] POP_SIG = {
    16'h5355, 16'h4F4C, 16'h5550, 16'h4F50
  };
  localparam logic [POP_SIG_WORDS-1:0][POP_ROW_LSB-1:0] POP_SIG_OFS = {
    4'd12, 4'd10, 4'd8, 4'd6
  };

  // controller side
  localparam int NUM_PADS = 5;
  // one spare code so an index past the last pad can be seen
  localparam int PORT_W = $clog2(NUM_PADS + 1);
  localparam int NIB_W = 4;
  localparam int JOY_WORD_W = 4 * NIB_W;

  // option levels from the host
  typedef struct packed {
    logic bit_reverse;
    logic six_button;
    logic multitap;
  } host_opts_t;

  // one 12-button pad, active high
  typedef struct packed {
    logic [3:0] ext_buttons;
    logic start;
    logic select;
    logic button_b;
    logic button_a;
    logic up;
    logic down;
    logic left;
    logic right;
  } pad_t;

  // write port towards the rom memory
  typedef struct packed {
    logic [ROM_ADDR_W-1:0] addr;
    logic [ROM_DATA_W-1:0] data;
  } rom_write_t;

  // nibble returned by a read, coded as {high-buttons phase, sel}
  typedef enum logic [1:0] {
    NIB_BUTTONS = 2'd0,
    NIB_DPAD = 2'd1,
    NIB_EXT = 2'd2,
    NIB_ID = 2'd3
  } pad_nibble_e;

endpackage
